/* rtl/gfx_geom_pkg.sv */
`default_nettype none

package gfx_geom_pkg;

    localparam int coord_w = 16;

    typedef logic [coord_w-1:0] coord_t;

    localparam coord_t screen_w = 16'd320;       // visible columns
    localparam coord_t screen_h = 16'd240;       // visible rows

    // one blit request
    typedef struct packed {
        coord_t            sheet_x;              // sheet start column
        coord_t            sheet_y;              // sheet start row
        coord_t            sheet_stride;         // sheet width in pixels
        coord_t            dst_x;                // screen start column
        coord_t            dst_y;                // screen start row
        coord_t            width;                // destination width
        coord_t            height;               // destination height
        logic signed [7:0] scale_x;              // >0 repeat, <0 skip
        logic signed [7:0] scale_y;
        logic              mirror_x;
        logic              mirror_y;
    } blit_req_t;

    // One destination pixel as produced by the coordinate generator.
    // sheet_y is carried already multiplied by the sheet stride, so the
    // sheet address stage needs no multiplier and no copy of the request.
    typedef struct packed {
        logic [31:0] sheet_x;                    // sheet column
        logic [31:0] sheet_y;                    // sheet row times stride
        coord_t      scr_x;                      // screen column, unclipped
        coord_t      scr_y;                      // screen row, unclipped
        logic        last;                       // final pixel of the blit
    } pix_coord_t;

endpackage

`default_nettype wire

/* rtl/gfx_mem_pkg.sv */
`default_nettype none

package gfx_mem_pkg;

    localparam int addr_w = 32;

    typedef logic [addr_w-1:0] addr_t;

    localparam addr_t pix_bytes  = addr_t'(2);             // 16 bit pixels
    localparam addr_t sheet_base = addr_t'(32'h0010_0000); // sprite sheet region
    localparam addr_t fb_base    = addr_t'(32'h0000_0000); // framebuffer region

    // sheet path payload
    typedef struct packed {
        addr_t addr;
        logic  last;
    } sheet_addr_t;

    // screen path payload
    typedef struct packed {
        addr_t addr;
        logic  clipped;                          // pixel lies off screen
        logic  last;
    } scr_addr_t;

    // one pixel copy for the memory side
    typedef struct packed {
        addr_t src;
        addr_t dst;
    } copy_cmd_t;

endpackage

`default_nettype wire

/* rtl/pipe_skid.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_skid #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic rst,
    input  payload_t  in_data,
    input  wire logic in_valid,
    output logic      in_ready,
    output payload_t  out_data,
    output logic      out_valid,
    input  wire logic out_ready
);

    typedef enum logic [1:0] {
        st_empty,
        st_full,
        st_buf_full
    } skid_state_t;

    skid_state_t state;
    payload_t    skid_data;                      // holds the beat that arrived during a stall

    logic in_fire;
    logic out_fire;

    assign in_fire   = in_valid && in_ready;
    assign out_fire  = out_valid && out_ready;
    assign out_valid = (state != st_empty);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_empty;
            in_ready <= 1'b1;
        end else begin
            unique case (state)
                st_empty: begin
                    if (in_fire) state <= st_full;
                end
                st_full: begin
                    if (in_fire && !out_fire) begin
                        state    <= st_buf_full;
                        in_ready <= 1'b0;      // stop until the skid drains
                    end else if (!in_fire && out_fire) begin
                        state <= st_empty;
                    end
                end
                st_buf_full: begin
                    if (out_fire) begin
                        state    <= st_full;
                        in_ready <= 1'b1;
                    end
                end
                default: state <= st_empty;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_buf_full) begin
            if (out_fire) out_data <= skid_data;
        end else if (in_fire) begin
            if (state == st_empty || out_fire) out_data <= in_data;
            else skid_data <= in_data;             // main is stalled
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* rtl/sprite_coord_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_coord_gen (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  gfx_geom_pkg::blit_req_t        req,
    input  wire logic                      req_valid,
    output logic                           req_ready,
    output gfx_geom_pkg::pix_coord_t       pix,
    output logic                           pix_valid,
    input  wire logic                      pix_ready
);

    logic req_fire;
    logic pix_fire;

    assign req_fire = req_valid && req_ready;
    assign pix_fire = pix_valid && pix_ready;

    // latched request geometry
    gfx_geom_pkg::coord_t w_last;                // width - 1
    gfx_geom_pkg::coord_t h_last;                // height - 1
    gfx_geom_pkg::coord_t x_start;               // sheet column at row start
    gfx_geom_pkg::coord_t row_scr_x;             // screen column at row start
    logic                 mir_x;
    logic                 mir_y;
    logic [7:0]           step_x;                // sheet columns per advance
    logic [7:0]           sub_max_x;             // repeats minus one or zero when downscaling
    logic [7:0]           sub_max_y;
    logic [31:0]          step_y;                // sheet row advance times stride

    // walk state
    gfx_geom_pkg::coord_t col;
    gfx_geom_pkg::coord_t row;
    logic [7:0]           sub_x;
    logic [7:0]           sub_y;

    // scale decode for the incoming request
    logic [7:0] mag_x;
    logic [7:0] mag_y;
    logic [7:0] step_x_in;
    logic [7:0] step_y_in;
    logic [7:0] sub_max_x_in;
    logic [7:0] sub_max_y_in;

    always_comb begin
        mag_x = req.scale_x[7] ? -req.scale_x : req.scale_x;
        mag_y = req.scale_y[7] ? -req.scale_y : req.scale_y;
        if (mag_x == 8'd0) mag_x = 8'd1;         // zero scale acts as one
        if (mag_y == 8'd0) mag_y = 8'd1;
        step_x_in    = req.scale_x[7] ? mag_x : 8'd1;
        step_y_in    = req.scale_y[7] ? mag_y : 8'd1;
        sub_max_x_in = req.scale_x[7] ? 8'd0 : mag_x - 8'd1;
        sub_max_y_in = req.scale_y[7] ? 8'd0 : mag_y - 8'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
            req_ready <= 1'b0;
        end else if (req_fire) begin
            pix_valid <= 1'b1;
            req_ready <= 1'b0;
        end else if (pix_fire && pix.last) begin
            pix_valid <= 1'b0;
            req_ready <= 1'b1;
        end else if (!pix_valid) begin
            req_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            w_last    <= req.width - 16'd1;
            h_last    <= req.height - 16'd1;
            x_start   <= req.sheet_x;
            mir_x     <= req.mirror_x;
            mir_y     <= req.mirror_y;
            step_x    <= step_x_in;
            sub_max_x <= sub_max_x_in;
            sub_max_y <= sub_max_y_in;
            step_y    <= 32'(step_y_in) * 32'(req.sheet_stride);
            row_scr_x <= req.mirror_x ? req.dst_x + req.width - 16'd1 : req.dst_x;
            col       <= '0;
            row       <= '0;
            sub_x     <= '0;
            sub_y     <= '0;

            pix.sheet_x <= 32'(req.sheet_x);
            pix.sheet_y <= 32'(req.sheet_y) * 32'(req.sheet_stride);
            pix.scr_x   <= req.mirror_x ? req.dst_x + req.width - 16'd1 : req.dst_x;
            pix.scr_y   <= req.mirror_y ? req.dst_y + req.height - 16'd1 : req.dst_y;
            pix.last    <= (req.width == 16'd1) && (req.height == 16'd1);
        end else if (pix_fire && !pix.last) begin
            if (col == w_last) begin
                // wrap to the next row
                col         <= '0;
                row         <= row + 16'd1;
                sub_x       <= '0;
                pix.sheet_x <= 32'(x_start);
                pix.scr_x   <= row_scr_x;
                pix.scr_y   <= mir_y ? pix.scr_y - 16'd1 : pix.scr_y + 16'd1;
                pix.last    <= (row + 16'd1 == h_last) && (w_last == 16'd0);
                if (sub_y == sub_max_y) begin
                    sub_y       <= '0;
                    pix.sheet_y <= pix.sheet_y + step_y;
                end else begin
                    sub_y <= sub_y + 8'd1;
                end
            end else begin
                col       <= col + 16'd1;
                pix.scr_x <= mir_x ? pix.scr_x - 16'd1 : pix.scr_x + 16'd1;
                pix.last  <= (col + 16'd1 == w_last) && (row == h_last);
                if (sub_x == sub_max_x) begin
                    sub_x       <= '0;
                    pix.sheet_x <= pix.sheet_x + 32'(step_x);
                end else begin
                    sub_x <= sub_x + 8'd1;
                end
            end
        end
    end

    a_last_on_final: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> pix.last == ((col == w_last) && (row == h_last)));

endmodule

`default_nettype wire

/* rtl/sheet_addr_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module sheet_addr_calc (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  gfx_geom_pkg::pix_coord_t   pix,
    input  wire logic                  pix_valid,
    output logic                       pix_ready,
    output gfx_mem_pkg::sheet_addr_t   addr,
    output logic                       addr_valid,
    input  wire logic                  addr_ready
);

    gfx_mem_pkg::sheet_addr_t calc_data;
    logic                     calc_valid;
    logic                     calc_ready;        // skid can take the computed beat

    assign pix_ready = !calc_valid || calc_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            calc_valid <= 1'b0;
        end else if (pix_ready) begin
            calc_valid <= pix_valid;
        end
    end

    // sheet_y already holds row times stride
    always_ff @(posedge clk) begin
        if (pix_valid && pix_ready) begin
            calc_data.addr <= gfx_mem_pkg::sheet_base
                            + gfx_mem_pkg::pix_bytes * (pix.sheet_y + pix.sheet_x);
            calc_data.last <= pix.last;
        end
    end

    pipe_skid #(
        .payload_t (gfx_mem_pkg::sheet_addr_t)
    ) pipe_skid_inst (
        .clk       (clk),
        .rst       (rst),
        .in_data   (calc_data),
        .in_valid  (calc_valid),
        .in_ready  (calc_ready),
        .out_data  (addr),
        .out_valid (addr_valid),
        .out_ready (addr_ready)
    );

endmodule

`default_nettype wire

/* rtl/screen_addr_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module screen_addr_calc (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  gfx_geom_pkg::pix_coord_t   pix,
    input  wire logic                  pix_valid,
    output logic                       pix_ready,
    output gfx_mem_pkg::scr_addr_t     addr,
    output logic                       addr_valid,
    input  wire logic                  addr_ready
);

    gfx_mem_pkg::scr_addr_t calc_data;
    logic                   calc_valid;
    logic                   calc_ready;

    gfx_mem_pkg::addr_t pix_index;               // linear framebuffer pixel
    logic               off_screen;

    assign pix_ready  = !calc_valid || calc_ready;
    assign pix_index  = gfx_mem_pkg::addr_t'(pix.scr_y)
                      * gfx_mem_pkg::addr_t'(gfx_geom_pkg::screen_w)
                      + gfx_mem_pkg::addr_t'(pix.scr_x);
    // negative positions wrap to large values and clip here too
    assign off_screen = (pix.scr_x >= gfx_geom_pkg::screen_w)
                     || (pix.scr_y >= gfx_geom_pkg::screen_h);

    always_ff @(posedge clk) begin
        if (rst) begin
            calc_valid <= 1'b0;
        end else if (pix_ready) begin
            calc_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid && pix_ready) begin
            calc_data.addr    <= gfx_mem_pkg::fb_base + gfx_mem_pkg::pix_bytes * pix_index;
            calc_data.clipped <= off_screen;
            calc_data.last    <= pix.last;
        end
    end

    pipe_skid #(
        .payload_t (gfx_mem_pkg::scr_addr_t)
    ) pipe_skid_inst (
        .clk       (clk),
        .rst       (rst),
        .in_data   (calc_data),
        .in_valid  (calc_valid),
        .in_ready  (calc_ready),
        .out_data  (addr),
        .out_valid (addr_valid),
        .out_ready (addr_ready)
    );

endmodule

`default_nettype wire

/* rtl/copy_cmd_join.sv */
`timescale 1ns/1ps
`default_nettype none

module copy_cmd_join (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  gfx_mem_pkg::sheet_addr_t   src,
    input  wire logic                  src_valid,
    output logic                       src_ready,
    input  gfx_mem_pkg::scr_addr_t     dst,
    input  wire logic                  dst_valid,
    output logic                       dst_ready,
    output gfx_mem_pkg::copy_cmd_t     cmd,
    output logic                       cmd_valid,
    input  wire logic                  cmd_ready,
    output logic                       blit_done
);

    // The output slot holds either a command or, for a clipped last
    // pixel, a bare end marker that drains on its own a cycle later.
    logic hold_valid;
    logic hold_send;                             // slot carries a real command
    logic hold_last;

    logic drain;
    logic take;

    assign drain     = hold_valid && (!hold_send || cmd_ready);
    assign take      = src_valid && dst_valid && (!hold_valid || drain);
    assign src_ready = take;
    assign dst_ready = take;
    assign cmd_valid = hold_valid && hold_send;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            hold_send  <= 1'b0;
            hold_last  <= 1'b0;
            blit_done  <= 1'b0;
        end else begin
            blit_done <= drain && hold_last;
            if (take) begin
                hold_valid <= !dst.clipped || dst.last;  // plain clipped pixels vanish
                hold_send  <= !dst.clipped;
                hold_last  <= dst.last;
            end else if (drain) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd.src <= src.addr;
            cmd.dst <= dst.addr;
        end
    end

    a_last_aligned: assert property (@(posedge clk) disable iff (rst)
        src_valid && dst_valid |-> src.last == dst.last);

endmodule

`default_nettype wire

/* rtl/sprite_blit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_blit_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  gfx_geom_pkg::blit_req_t    req,
    input  wire logic                  req_valid,
    output logic                       req_ready,
    output gfx_mem_pkg::copy_cmd_t     cmd,
    output logic                       cmd_valid,
    input  wire logic                  cmd_ready,
    output logic                       blit_done
);

    gfx_geom_pkg::pix_coord_t pix;
    logic                     pix_valid;
    logic                     pix_ready;
    logic                     sheet_pix_ready;
    logic                     scr_pix_ready;

    gfx_mem_pkg::sheet_addr_t sheet_addr;
    logic                     sheet_valid;
    logic                     sheet_ready;
    gfx_mem_pkg::scr_addr_t   scr_addr;
    logic                     scr_valid;
    logic                     scr_ready;

    assign pix_ready = sheet_pix_ready && scr_pix_ready;  // fork to both paths

    sprite_coord_gen sprite_coord_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .pix       (pix),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready)
    );

    sheet_addr_calc sheet_addr_calc_inst (
        .clk        (clk),
        .rst        (rst),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .pix_ready  (sheet_pix_ready),
        .addr       (sheet_addr),
        .addr_valid (sheet_valid),
        .addr_ready (sheet_ready)
    );

    screen_addr_calc screen_addr_calc_inst (
        .clk        (clk),
        .rst        (rst),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .pix_ready  (scr_pix_ready),
        .addr       (scr_addr),
        .addr_valid (scr_valid),
        .addr_ready (scr_ready)
    );

    copy_cmd_join copy_cmd_join_inst (
        .clk       (clk),
        .rst       (rst),
        .src       (sheet_addr),
        .src_valid (sheet_valid),
        .src_ready (sheet_ready),
        .dst       (scr_addr),
        .dst_valid (scr_valid),
        .dst_ready (scr_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .blit_done (blit_done)
    );

endmodule

`default_nettype wire

/* sim/tb_blit_checks.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_blit_checks (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire gfx_geom_pkg::blit_req_t req,
    input  wire logic                    req_valid,
    input  wire logic                    req_ready,
    input  wire gfx_mem_pkg::copy_cmd_t  cmd,
    input  wire logic                    cmd_valid,
    input  wire logic                    cmd_ready,
    input  wire logic                    blit_done,
    output logic                         check_err,
    output int                           open_blits,
    output int                           open_cmds
);

    gfx_mem_pkg::copy_cmd_t exp_q[$];             // expected commands in send order
    int                     cnt_q[$];             // commands left per open blit

    gfx_mem_pkg::copy_cmd_t exp_head = '0;        // queue heads as seen before the edge
    logic                   exp_any  = 1'b0;
    logic                   blit_any = 1'b0;
    int                     cnt_head = 0;

    logic err_unexpected = 1'b0;
    logic err_value      = 1'b0;
    logic err_stable     = 1'b0;
    logic err_done       = 1'b0;
    logic err_ready      = 1'b0;

    assign check_err = err_unexpected || err_value || err_stable || err_done || err_ready;

    // walk the destination rectangle row by row and keep on-screen pixels
    task automatic expand_request(input gfx_geom_pkg::blit_req_t r);
        int                     sc_x;
        int                     sc_y;
        int                     mag_x;
        int                     mag_y;
        int                     kept;
        logic [31:0]            src_x;
        logic [31:0]            src_y;
        logic [15:0]            scr_x;
        logic [15:0]            scr_y;
        gfx_mem_pkg::copy_cmd_t c;
        sc_x  = int'($signed(r.scale_x));
        sc_y  = int'($signed(r.scale_y));
        mag_x = (sc_x < 0) ? -sc_x : ((sc_x == 0) ? 1 : sc_x);
        mag_y = (sc_y < 0) ? -sc_y : ((sc_y == 0) ? 1 : sc_y);
        kept  = 0;
        for (int row = 0; row < int'(r.height); row++) begin
            for (int col = 0; col < int'(r.width); col++) begin
                src_x = 32'(r.sheet_x) + 32'((sc_x < 0) ? col * mag_x : col / mag_x);
                src_y = 32'(r.sheet_y) + 32'((sc_y < 0) ? row * mag_y : row / mag_y);
                scr_x = r.mirror_x ? r.dst_x + r.width - 16'd1 - 16'(col) : r.dst_x + 16'(col);
                scr_y = r.mirror_y ? r.dst_y + r.height - 16'd1 - 16'(row)
                                   : r.dst_y + 16'(row);
                if (scr_x < gfx_geom_pkg::screen_w && scr_y < gfx_geom_pkg::screen_h) begin
                    c.src = gfx_mem_pkg::sheet_base
                          + gfx_mem_pkg::pix_bytes * (src_y * 32'(r.sheet_stride) + src_x);
                    c.dst = gfx_mem_pkg::fb_base
                          + gfx_mem_pkg::pix_bytes * (32'(scr_y) * 32'd320 + 32'(scr_x));
                    exp_q.push_back(c);
                    kept++;
                end
            end
        end
        cnt_q.push_back(kept);                    // zero for a blit fully off screen
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            cnt_q.delete();
        end else begin
            // a done closes the oldest blit before a same-edge command of the next one
            if (blit_done && cnt_q.size() != 0) void'(cnt_q.pop_front());
            if (cmd_valid && cmd_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                if (cnt_q.size() != 0) cnt_q[0] = cnt_q[0] - 1;
            end
            if (req_valid && req_ready) expand_request(req);
        end
        exp_any    <= (exp_q.size() != 0);
        exp_head   <= (exp_q.size() != 0) ? exp_q[0] : '0;
        blit_any   <= (cnt_q.size() != 0);
        cnt_head   <= (cnt_q.size() != 0) ? cnt_q[0] : 0;
        open_blits <= cnt_q.size();
        open_cmds  <= exp_q.size();
    end

    a_req_ready_drop: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> !req_ready)
        else begin
            $display("Error at time %0t: req_ready expected 0, got 1 after acceptance",
                     $time);
            err_ready = 1'b1;
        end

    a_cmd_expected: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && cmd_ready |-> exp_any)
        else begin
            $display("Error at time %0t: cmd_valid expected 0, got 1 with nothing expected",
                     $time);
            err_unexpected = 1'b1;
        end

    a_cmd_value: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && cmd_ready && exp_any |-> cmd == exp_head)
        else begin
            $display("Error at time %0t: cmd expected %h, got %h",
                     $time, $sampled(exp_head), $sampled(cmd));
            err_value = 1'b1;
        end

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else begin
            $display("Error at time %0t: cmd changed or cmd_valid dropped while stalled",
                     $time);
            err_stable = 1'b1;
        end

    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        blit_done |-> blit_any && cnt_head == 0)
        else begin
            $display("Error at time %0t: blit_done expected 0, got 1 (%0d commands left)",
                     $time, $sampled(cnt_head));
            err_done = 1'b1;
        end

endmodule

`default_nettype wire

/* sim/tb_sprite_blit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_blit;

    logic                    clk          = 1'b0;
    logic                    rst          = 1'b1;
    gfx_geom_pkg::blit_req_t req          = '0;
    logic                    req_valid    = 1'b0;
    logic                    req_ready;
    gfx_mem_pkg::copy_cmd_t  cmd;
    logic                    cmd_valid;
    logic                    cmd_ready    = 1'b0;
    logic                    blit_done;
    logic                    check_err;
    int                      open_blits;
    int                      open_cmds;
    integer                  seed         = 32'h00e4faec;
    logic                    ready_random = 1'b0;
    logic [31:0]             rnd_ready;
    int                      cycles       = 0;
    int                      cycle_limit  = 0;
    int                      n_directed   = 0;
    gfx_geom_pkg::blit_req_t reqs[$];

    always #20 clk = ~clk;                        // 40 ns period

    sprite_blit_top sprite_blit_top_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .blit_done (blit_done)
    );

    tb_blit_checks checks_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .blit_done  (blit_done),
        .check_err  (check_err),
        .open_blits (open_blits),
        .open_cmds  (open_cmds)
    );

    function automatic gfx_geom_pkg::blit_req_t blit_request(
        input int sx, input int sy, input int stride, input int dx, input int dy,
        input int w, input int h, input int scx, input int scy, input bit mx, input bit my);
        gfx_geom_pkg::blit_req_t r;
        r.sheet_x      = 16'(sx);
        r.sheet_y      = 16'(sy);
        r.sheet_stride = 16'(stride);
        r.dst_x        = 16'(dx);
        r.dst_y        = 16'(dy);
        r.width        = 16'(w);
        r.height       = 16'(h);
        r.scale_x      = 8'(scx);
        r.scale_y      = 8'(scy);
        r.mirror_x     = mx;
        r.mirror_y     = my;
        return r;
    endfunction

    // hold the request until the generator takes it
    task automatic send_request(input gfx_geom_pkg::blit_req_t r);
        @(negedge clk);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);                           // transfer happened on the edge between
        req_valid = 1'b0;
    endtask

    task automatic wait_blits_done();
        @(negedge clk);
        while (open_blits != 0) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (ready_random) begin
            rnd_ready = $random(seed);
            cmd_ready = (rnd_ready[1:0] != 2'b00);  // ready about three cycles in four
        end else begin
            cmd_ready = !rst;
        end
    end

    always @(negedge clk) begin
        if (check_err) begin
            $display("*** FAILED ***");
            $fatal(1, "stopping at the first failed check");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the blits did not finish", cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int          total;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        total = 0;
        reqs.push_back(blit_request(0, 0, 64, 10, 20, 4, 3, 1, 1, 0, 0));
        reqs.push_back(blit_request(4, 2, 64, 50, 60, 4, 3, 1, 1, 1, 1));
        reqs.push_back(blit_request(8, 8, 32, 100, 100, 6, 6, 3, 3, 0, 0));
        reqs.push_back(blit_request(2, 1, 128, 200, 10, 5, 4, -2, -2, 0, 0));
        reqs.push_back(blit_request(0, 0, 64, 317, 237, 5, 4, 1, 1, 0, 0));
        reqs.push_back(blit_request(0, 0, 64, 400, 300, 3, 2, 1, 1, 0, 0));
        reqs.push_back(blit_request(3, 3, 64, 0, 0, 3, 2, 0, 0, 1, 0));
        n_directed = reqs.size();
        repeat (16) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            reqs.push_back(blit_request(int'(rnd_b[22:18]), int'(rnd_b[27:23]),
                64 + 4 * int'(rnd_b[31:28]), int'(rnd_b[8:0] % 336), int'(rnd_b[17:9] % 252),
                1 + int'(rnd_a[2:0]), 1 + int'(rnd_a[5:3]),
                int'(rnd_a[8:6]) - 3, int'(rnd_a[11:9]) - 3, rnd_a[12], rnd_a[13]));
        end
        foreach (reqs[i]) total += int'(reqs[i].width) * int'(reqs[i].height);
        cycle_limit = 4 * total + 40 * reqs.size() + 100;   // margin for stalls
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_directed; i++) begin
            send_request(reqs[i]);
            wait_blits_done();
        end
        ready_random = 1'b1;
        for (int i = n_directed; i < reqs.size(); i++) send_request(reqs[i]);
        wait_blits_done();
        if (check_err || open_cmds != 0) begin
            $display("Run ended with %0d expected commands never seen", open_cmds);
            $display("*** FAILED ***");
            $fatal(1, "run failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/gfx_geom_pkg.sv
rtl/gfx_mem_pkg.sv
rtl/pipe_skid.sv
rtl/sprite_coord_gen.sv
rtl/sheet_addr_calc.sv
rtl/screen_addr_calc.sv
rtl/copy_cmd_join.sv
rtl/sprite_blit_top.sv
sim/tb_blit_checks.sv
sim/tb_sprite_blit.sv

/* run.sh */
#!/bin/sh
# Build and run the sprite blitter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sprite_blit -f flist.f -o tb_sprite_blit
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sprite_blit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
